//--- dcpl_defs.svh
/* Stage counts and data widths for the decoupling boundary */

`ifndef DCPL_DEFS_SVH
`define DCPL_DEFS_SVH

// Decouple pipeline depth, input tap included
`define DCPL_SYNC_STAGES 3

// Register slices behind each gate
`define DCPL_N_STAGES 3

`define DCPL_IRQ_BITS 15   // User interrupt vector

`define DCPL_DATA_BITS 64  // User stream payload

`define DCPL_WB_BITS 32    // Writeback beat payload

`endif

//--- dcpl_channel.sv
/* Isolation gate followed by a chain of skid register slices
   for one valid/ready channel */

`timescale 1ns/1ps

module dcpl_channel #(
    parameter int DATA_BITS = 65,
    parameter int N_STAGES  = 3
) (
    input  logic                 aclk,
    input  logic                 aresetn,
    input  logic                 gate_on,

    input  logic                 s_valid,
    output logic                 s_ready,
    input  logic [DATA_BITS-1:0] s_data,

    output logic                 m_valid,
    input  logic                 m_ready,
    output logic [DATA_BITS-1:0] m_data
);

    logic                 vld [N_STAGES+1];
    logic                 rdy [N_STAGES+1];
    logic [DATA_BITS-1:0] dat [N_STAGES+1];

    // Gate on the source side
    assign vld[0]  = s_valid && !gate_on;
    assign s_ready = rdy[0] && !gate_on;
    assign dat[0]  = s_data;

    for (genvar i = 0; i < N_STAGES; i++) begin : g_slice
        logic                 main_vld;
        logic [DATA_BITS-1:0] main_dat;
        logic                 spare_vld;
        logic [DATA_BITS-1:0] spare_dat;
        logic                 in_rdy;

        always_ff @(posedge aclk) begin
            if (!aresetn) begin
                main_vld  <= 1'b0;
                spare_vld <= 1'b0;
                in_rdy    <= 1'b0;
            end else if (!spare_vld) begin
                in_rdy <= 1'b1;
                if (!main_vld || rdy[i+1]) begin
                    main_vld <= vld[i] && in_rdy;   // Main free or draining
                end else if (vld[i] && in_rdy) begin
                    spare_vld <= 1'b1;              // Main stalled so park in spare
                    in_rdy    <= 1'b0;
                end
            end else if (rdy[i+1]) begin
                // Spare moves into main, which stays valid
                spare_vld <= 1'b0;
                in_rdy    <= 1'b1;
            end
        end

        always_ff @(posedge aclk) begin
            if (!spare_vld) begin
                if (!main_vld || rdy[i+1]) begin
                    main_dat <= dat[i];
                end else if (vld[i] && in_rdy) begin
                    spare_dat <= dat[i];
                end
            end else if (rdy[i+1]) begin
                main_dat <= spare_dat;
            end
        end

        assign rdy[i]   = in_rdy;     // Registered ready upstream
        assign vld[i+1] = main_vld;
        assign dat[i+1] = main_dat;
    end

    assign m_valid        = vld[N_STAGES];
    assign m_data         = dat[N_STAGES];
    assign rdy[N_STAGES]  = m_ready;

    // Stalled beat holds at the output
    a_out_stable: assert property (@(posedge aclk) disable iff (!aresetn)
        m_valid && !m_ready |=> m_valid && $stable(m_data));

    // Nothing enters the first slice while isolated
    a_no_entry: assert property (@(posedge aclk) disable iff (!aresetn)
        gate_on |=> !$rose(g_slice[0].main_vld) && !$rose(g_slice[0].spare_vld));

endmodule

//--- dcpl_pkg.sv
/* Writeback request and DMA write descriptor types */

`include "dcpl_defs.svh"

package dcpl_pkg;

    // Writeback from the user region
    typedef struct packed {
        logic [63:0]               addr;   // Host address
        logic [`DCPL_WB_BITS-1:0]  value;  // Word to write
    } wback_t;

    // DMA write descriptor toward the shell
    typedef struct packed {
        logic [63:0] addr;  // Host address
        logic [31:0] len;   // Length in bytes
    } dma_req_t;

endpackage

//--- dcpl_wback_dma.sv
/* Writeback to DMA conversion, one descriptor and one 32-bit beat
   per accepted request */

`timescale 1ns/1ps

`include "dcpl_defs.svh"

module dcpl_wback_dma (
    input  logic                     aclk,
    input  logic                     aresetn,

    input  logic                     s_valid,
    output logic                     s_ready,
    input  dcpl_pkg::wback_t         s_req,

    output logic                     dma_valid,
    input  logic                     dma_ready,
    output dcpl_pkg::dma_req_t       dma_req,

    output logic                     wbs_valid,
    input  logic                     wbs_ready,
    output logic [`DCPL_WB_BITS-1:0] wbs_data,
    output logic                     wbs_last
);

    logic accept;
    logic dma_busy_nxt;
    logic wbs_busy_nxt;

    assign accept       = s_valid && s_ready;
    assign dma_busy_nxt = accept || (dma_valid && !dma_ready);
    assign wbs_busy_nxt = accept || (wbs_valid && !wbs_ready);

    // Each output clears on its own handshake
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            dma_valid <= 1'b0;
            wbs_valid <= 1'b0;
            s_ready   <= 1'b0;
        end else begin
            dma_valid <= dma_busy_nxt;
            wbs_valid <= wbs_busy_nxt;
            s_ready   <= !dma_busy_nxt && !wbs_busy_nxt;  // Both sides idle
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) begin
            dma_req.addr <= s_req.addr;
            dma_req.len  <= 32'(`DCPL_WB_BITS / 8);  // One word in bytes
            wbs_data     <= s_req.value;
        end
    end

    assign wbs_last = 1'b1;  // Single-beat stream

    // No new request while a previous one is still pending
    a_one_in_flight: assert property (@(posedge aclk) disable iff (!aresetn)
        s_ready |-> !dma_valid && !wbs_valid);

endmodule

//--- dcpl_static.sv
/* Static decoupling boundary top with the decouple pipeline, gated interrupts,
   gated stream channels and writeback conversion */

`timescale 1ns/1ps

`include "dcpl_defs.svh"

module dcpl_static (
    input  logic                       aclk,
    input  logic                       aresetn,
    input  logic                       decouple,

    input  logic [`DCPL_IRQ_BITS-1:0]  usr_irq_in,
    output logic [`DCPL_IRQ_BITS-1:0]  irq_out,

    input  logic                       uo_valid,
    output logic                       uo_ready,
    input  logic [`DCPL_DATA_BITS-1:0] uo_data,
    input  logic                       uo_last,
    output logic                       so_valid,
    input  logic                       so_ready,
    output logic [`DCPL_DATA_BITS-1:0] so_data,
    output logic                       so_last,

    input  logic                       si_valid,
    output logic                       si_ready,
    input  logic [`DCPL_DATA_BITS-1:0] si_data,
    input  logic                       si_last,
    output logic                       ui_valid,
    input  logic                       ui_ready,
    output logic [`DCPL_DATA_BITS-1:0] ui_data,
    output logic                       ui_last,

    input  logic                       wb_valid,
    output logic                       wb_ready,
    input  dcpl_pkg::wback_t           wb_req,

    output logic                       dma_valid,
    input  logic                       dma_ready,
    output dcpl_pkg::dma_req_t         dma_req,
    output logic                       wbs_valid,
    input  logic                       wbs_ready,
    output logic [`DCPL_WB_BITS-1:0]   wbs_data,
    output logic                       wbs_last
);

    logic [`DCPL_SYNC_STAGES-1:0] dcpl_q;
    logic                         gate_on;
    logic [`DCPL_IRQ_BITS-1:0]    irq_gated;
    logic [`DCPL_IRQ_BITS-1:0]    irq_pipe [`DCPL_N_STAGES];
    logic                         si_q_valid;
    logic                         si_q_ready;
    logic                         wb_q_valid;
    logic                         wb_q_ready;
    dcpl_pkg::wback_t             wb_q_req;

    // Input tap plus registered stages
    assign dcpl_q[0] = decouple;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            dcpl_q[`DCPL_SYNC_STAGES-1:1] <= '0;
        end else begin
            dcpl_q[`DCPL_SYNC_STAGES-1:1] <= dcpl_q[`DCPL_SYNC_STAGES-2:0];
        end
    end

    assign gate_on = dcpl_q[`DCPL_SYNC_STAGES-1];

    // Interrupts forced low while isolated and then sliced
    assign irq_gated = gate_on ? '0 : usr_irq_in;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            for (int i = 0; i < `DCPL_N_STAGES; i++) begin
                irq_pipe[i] <= '0;
            end
        end else begin
            irq_pipe[0] <= irq_gated;
            for (int i = 1; i < `DCPL_N_STAGES; i++) begin
                irq_pipe[i] <= irq_pipe[i-1];
            end
        end
    end

    assign irq_out = irq_pipe[`DCPL_N_STAGES-1];

    // User to shell gated at the user input
    dcpl_channel #(.DATA_BITS(`DCPL_DATA_BITS + 1), .N_STAGES(`DCPL_N_STAGES)) u_ch_out (
        .aclk(aclk), .aresetn(aresetn), .gate_on(gate_on),
        .s_valid(uo_valid), .s_ready(uo_ready), .s_data({uo_last, uo_data}),
        .m_valid(so_valid), .m_ready(so_ready), .m_data({so_last, so_data})
    );

    // Shell to user with the gate at the user edge below
    dcpl_channel #(.DATA_BITS(`DCPL_DATA_BITS + 1), .N_STAGES(`DCPL_N_STAGES)) u_ch_in (
        .aclk(aclk), .aresetn(aresetn), .gate_on(1'b0),
        .s_valid(si_valid), .s_ready(si_ready), .s_data({si_last, si_data}),
        .m_valid(si_q_valid), .m_ready(si_q_ready), .m_data({ui_last, ui_data})
    );

    assign ui_valid   = si_q_valid && !gate_on;
    assign si_q_ready = ui_ready && !gate_on;  // Slices hold while isolated

    // Writeback request from the user
    dcpl_channel #(.DATA_BITS($bits(dcpl_pkg::wback_t)), .N_STAGES(`DCPL_N_STAGES)) u_ch_wb (
        .aclk(aclk), .aresetn(aresetn), .gate_on(gate_on),
        .s_valid(wb_valid), .s_ready(wb_ready), .s_data(wb_req),
        .m_valid(wb_q_valid), .m_ready(wb_q_ready), .m_data(wb_q_req)
    );

    dcpl_wback_dma u_wback_dma (
        .aclk(aclk), .aresetn(aresetn),
        .s_valid(wb_q_valid), .s_ready(wb_q_ready), .s_req(wb_q_req),
        .dma_valid(dma_valid), .dma_ready(dma_ready), .dma_req(dma_req),
        .wbs_valid(wbs_valid), .wbs_ready(wbs_ready),
        .wbs_data(wbs_data), .wbs_last(wbs_last)
    );

    // Isolation reaches irq_out after the slice depth
    a_irq_quiet: assert property (@(posedge aclk) disable iff (!aresetn)
        gate_on |-> ##`DCPL_N_STAGES (irq_out == '0));

endmodule

//--- tb_clock_gen.sv
/* Testbench clock and active-low synchronous reset */

`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 8
) (
    output logic aclk,
    output logic aresetn
);

    initial begin
        aclk = 1'b0;
        forever #(PERIOD_NS / 2) aclk = ~aclk;
    end

    initial begin
        aresetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge aclk);
        #2 aresetn = 1'b1;  // Released in step with the stimulus
    end

endmodule

//--- tb_dcpl_static.sv
/* Testbench for the decoupling boundary: random stream, interrupt and writeback
   traffic around an isolation window, checked by scoreboards and assertions */

`timescale 1ns/1ps

`include "dcpl_defs.svh"

module tb_dcpl_static;

    localparam int RUN_CYCLES = 800;  // Open traffic before and after isolation
    localparam int ISO_CYCLES = 150;  // Decouple held high
    localparam int MAX_CYCLES = 2 * (2 * RUN_CYCLES + ISO_CYCLES) + 500;
    localparam int GATE_LAG   = `DCPL_SYNC_STAGES - 1;
    localparam int IRQ_LAG    = GATE_LAG + `DCPL_N_STAGES;

    logic                       aclk;
    logic                       aresetn;
    logic                       decouple;
    logic [`DCPL_IRQ_BITS-1:0]  usr_irq_in;
    logic [`DCPL_IRQ_BITS-1:0]  irq_out;
    logic                       uo_valid, uo_ready, uo_last;
    logic [`DCPL_DATA_BITS-1:0] uo_data;
    logic                       so_valid, so_ready, so_last;
    logic [`DCPL_DATA_BITS-1:0] so_data;
    logic                       si_valid, si_ready, si_last;
    logic [`DCPL_DATA_BITS-1:0] si_data;
    logic                       ui_valid, ui_ready, ui_last;
    logic [`DCPL_DATA_BITS-1:0] ui_data;
    logic                       wb_valid, wb_ready;
    dcpl_pkg::wback_t           wb_req;
    logic                       dma_valid, dma_ready;
    dcpl_pkg::dma_req_t         dma_req;
    logic                       wbs_valid, wbs_ready, wbs_last;
    logic [`DCPL_WB_BITS-1:0]   wbs_data;

    logic [`DCPL_DATA_BITS:0]   out_q [$];  // {last, data} expected at the shell
    logic [`DCPL_DATA_BITS:0]   in_q [$];   // {last, data} expected at the user
    dcpl_pkg::wback_t           dma_q [$];  // Requests awaiting a descriptor
    logic [`DCPL_WB_BITS-1:0]   wbs_q [$];  // Values awaiting their beat
    logic [31:0]                rng = 32'd51252;
    int                         cycles = 0;
    int                         n_wb = 0;

    tb_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(8)) u_clock (.aclk(aclk), .aresetn(aresetn));

    dcpl_static DUT (.*);

    task automatic stop_with_error(input string line);
        $display("%s", line);
        $display("Regression failed");
        $fatal(1, "simulation stopped on error");
    endtask

    function automatic logic [31:0] xorshift32();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic bit chance(input int unsigned pct);
        return (xorshift32() % 100) < pct;
    endfunction

    // One cycle of stimulus; a source only changes after its handshake
    task automatic drive_cycle(input int unsigned pct_new);
        bit          uo_fire;
        bit          si_fire;
        bit          wb_fire;
        logic [31:0] r;
        @(negedge aclk);
        uo_fire = uo_valid && uo_ready;
        si_fire = si_valid && si_ready;
        wb_fire = wb_valid && wb_ready;
        @(posedge aclk);
        #2;
        if (!uo_valid || uo_fire) begin
            r        = xorshift32();
            uo_valid = chance(pct_new);
            uo_data  = {xorshift32(), r};
            uo_last  = r[31];
        end
        if (!si_valid || si_fire) begin
            r        = xorshift32();
            si_valid = chance(pct_new);
            si_data  = {r, xorshift32()};
            si_last  = r[0];
        end
        if (!wb_valid || wb_fire) begin
            wb_valid     = chance(pct_new / 2);  // Writebacks are rarer
            wb_req.addr  = {xorshift32(), xorshift32()};
            wb_req.value = xorshift32();
        end
        r          = xorshift32();
        usr_irq_in = r[`DCPL_IRQ_BITS-1:0];
        so_ready   = chance(70);
        ui_ready   = chance(70);
        dma_ready  = chance(60);
        wbs_ready  = chance(60);
    endtask

    // Handshakes are sampled mid-cycle, where every signal is settled
    always @(negedge aclk) begin : scoreboard
        logic [`DCPL_DATA_BITS:0] exp_beat;
        dcpl_pkg::wback_t         exp_wb;
        logic [`DCPL_WB_BITS-1:0] exp_val;
        if (aresetn) begin
            if (uo_valid && uo_ready) out_q.push_back({uo_last, uo_data});
            if (si_valid && si_ready) in_q.push_back({si_last, si_data});
            if (wb_valid && wb_ready) begin
                dma_q.push_back(wb_req);
                wbs_q.push_back(wb_req.value);
                n_wb++;
            end
            if (so_valid && so_ready) begin
                assert (out_q.size() != 0)
                    else stop_with_error($sformatf("[FAIL] %0t: extra beat at the shell", $time));
                exp_beat = out_q.pop_front();
                assert ({so_last, so_data} == exp_beat)
                    else stop_with_error($sformatf("[FAIL] %0t: shell beat %h, expected %h",
                        $time, {so_last, so_data}, exp_beat));
            end
            if (ui_valid && ui_ready) begin
                assert (in_q.size() != 0)
                    else stop_with_error($sformatf("[FAIL] %0t: extra beat at the user", $time));
                exp_beat = in_q.pop_front();
                assert ({ui_last, ui_data} == exp_beat)
                    else stop_with_error($sformatf("[FAIL] %0t: user beat %h, expected %h",
                        $time, {ui_last, ui_data}, exp_beat));
            end
            if (dma_valid && dma_ready) begin
                assert (dma_q.size() != 0)
                    else stop_with_error($sformatf("[FAIL] %0t: extra DMA descriptor", $time));
                exp_wb = dma_q.pop_front();
                assert (dma_req.addr == exp_wb.addr && dma_req.len == 32'd4)
                    else stop_with_error($sformatf("[FAIL] %0t: descriptor %h/%0d, expected %h/4",
                        $time, dma_req.addr, dma_req.len, exp_wb.addr));
            end
            if (wbs_valid && wbs_ready) begin
                assert (wbs_q.size() != 0)
                    else stop_with_error($sformatf("[FAIL] %0t: extra writeback beat", $time));
                exp_val = wbs_q.pop_front();
                assert (wbs_data == exp_val && wbs_last)
                    else stop_with_error($sformatf("[FAIL] %0t: wbs beat %h last %b, expected %h",
                        $time, wbs_data, wbs_last, exp_val));
            end
        end
    end

    // Interrupts lag by the slice depth and read zero while isolated
    irq_delay: assert property (@(posedge aclk) disable iff (!aresetn)
        irq_out == ($past(decouple, IRQ_LAG) ? '0 : $past(usr_irq_in, `DCPL_N_STAGES)))
        else stop_with_error($sformatf("[FAIL] %0t: irq_out %h off its delayed input",
            $time, irq_out));

    isolation: assert property (@(posedge aclk) disable iff (!aresetn)
        $past(decouple, GATE_LAG) |-> !uo_ready && !wb_ready && !ui_valid)
        else stop_with_error($sformatf("[FAIL] %0t: user side open while isolated", $time));

    reset_state: assert property (@(posedge aclk)
        $rose(aresetn) |-> !so_valid && !ui_valid && !dma_valid && !wbs_valid
            && irq_out == '0 && !uo_ready && !si_ready && !wb_ready)
        else stop_with_error($sformatf("[FAIL] %0t: outputs not idle after reset", $time));

    always @(posedge aclk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            stop_with_error("Timeout: traffic did not drain within the cycle limit");
        end
    end

    initial begin
        decouple   = 1'b0;
        usr_irq_in = '0;
        uo_valid   = 1'b0;
        uo_data    = '0;
        uo_last    = 1'b0;
        so_ready   = 1'b0;
        si_valid   = 1'b0;
        si_data    = '0;
        si_last    = 1'b0;
        ui_ready   = 1'b0;
        wb_valid   = 1'b0;
        wb_req     = '0;
        dma_ready  = 1'b0;
        wbs_ready  = 1'b0;
        wait (aresetn);
        repeat (RUN_CYCLES) drive_cycle(60);
        decouple = 1'b1;  // Isolate with traffic in flight
        repeat (ISO_CYCLES) drive_cycle(60);
        decouple = 1'b0;
        repeat (RUN_CYCLES) drive_cycle(60);
        while (uo_valid || si_valid || wb_valid || out_q.size() != 0 || in_q.size() != 0
               || dma_q.size() != 0 || wbs_q.size() != 0) begin
            drive_cycle(0);  // Drain, no new requests
        end
        if (n_wb == 0) begin
            stop_with_error("No writeback request was accepted during the run");
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

//--- dcpl_static.f
+incdir+.
dcpl_channel.sv
dcpl_pkg.sv
dcpl_wback_dma.sv
dcpl_static.sv
tb_clock_gen.sv
tb_dcpl_static.sv

//--- run_sim.sh
#!/bin/sh
# Compile with Verilator, run, and decide on the pass line in the output
verilator --binary --timing --assert --top-module tb_dcpl_static -f dcpl_static.f \
    && ./obj_dir/Vtb_dcpl_static | tee /dev/stderr | grep -q "Regression passed" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
